// File: verilog/svc_pkg.sv
`default_nettype none

package svc_pkg;

  // ----------------------------------------
  // Command encoding
  // ----------------------------------------

  // The high nibble of every code is its group and the low nibble is the
  // command within that group
  typedef enum logic [7:0] {
    CMD_AWUSER_CORE     = 8'h10,
    CMD_AWUSER_MCU      = 8'h11,
    CMD_RELEASE_AWUSER  = 8'h12,
    CMD_ZEROIZE_SET     = 8'h20,
    CMD_ZEROIZE_CLEAR   = 8'h21,
    CMD_ZEROIZE_RELEASE = 8'h22,
    CMD_FORCE_TOKENS    = 8'h30,
    CMD_RMA_SCRAP_PPD   = 8'h31,
    CMD_ESCALATE        = 8'h32,
    CMD_CLK_500         = 8'h40,
    CMD_CLK_160         = 8'h41,
    CMD_CLK_400         = 8'h42,
    CMD_CLK_1000        = 8'h43,
    CMD_FAULT_BUS       = 8'h50,
    CMD_FAULT_DIGEST    = 8'h51,
    CMD_DOMAIN_RESET    = 8'h60
  } svc_cmd_e;

  localparam logic [3:0] GRP_OVERRIDE = 4'h1;
  localparam logic [3:0] GRP_ZEROIZE  = 4'h2;
  localparam logic [3:0] GRP_LC       = 4'h3;
  localparam logic [3:0] GRP_CLK      = 4'h4;
  localparam logic [3:0] GRP_FAULT    = 4'h5;
  localparam logic [3:0] GRP_DOMAIN   = 4'h6;

  // Same command byte, seen as a full opcode or as a group/index pair
  typedef union packed {
    svc_cmd_e opcode;
    struct packed {
      logic [3:0] group;
      logic [3:0] index;
    } fields;
  } svc_cmd_u;

  // Encoding matches the external clock mux select
  typedef enum logic [1:0] {
    F500  = 2'd0,
    F160  = 2'd1,
    F400  = 2'd2,
    F1000 = 2'd3
  } freq_e;

  localparam logic [1:0] AWUSER_NONE = 2'd0;
  localparam logic [1:0] AWUSER_CORE = 2'd1;
  localparam logic [1:0] AWUSER_MCU  = 2'd2;

  // ----------------------------------------
  // Decoder to datapath interface
  // ----------------------------------------

  // One pulse bit per command, at most one set in any cycle
  typedef struct packed {
    logic awuser_core;
    logic awuser_mcu;
    logic awuser_release;
    logic zeroize_set;
    logic zeroize_clear;
    logic zeroize_release;
    logic force_tokens;
    logic rma_scrap_ppd;
    logic escalate;
    logic clk_500;
    logic clk_160;
    logic clk_400;
    logic clk_1000;
    logic fault_bus;
    logic fault_digest;
    logic domain_reset;
  } svc_action_t;

  typedef struct packed {
    logic [1:0] awuser_sel;
    logic       zeroize_ppd;
    logic       rom_zero_mask_all;
    logic       scrap_mode_n;
    logic       zeroize_forced;
    logic       tokens_valid;
    logic       rma_scrap_ppd;
    logic       escalate;
    freq_e      freq_sel;
  } svc_ctrl_t;

  // Scrap mode is active low, so it idles high
  localparam svc_ctrl_t CTRL_RESET = '{
    awuser_sel:        AWUSER_NONE,
    zeroize_ppd:       1'b0,
    rom_zero_mask_all: 1'b0,
    scrap_mode_n:      1'b1,
    zeroize_forced:    1'b0,
    tokens_valid:      1'b0,
    rma_scrap_ppd:     1'b0,
    escalate:          1'b0,
    freq_sel:          F500
  };

endpackage

`default_nettype wire

// File: verilog/svc_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module svc_cmd_decoder import svc_pkg::*; (
  input  logic        clk,
  input  logic        cptra_rst_b,
  input  logic        cmd_valid_i,
  input  svc_cmd_u    cmd_i,
  input  logic        rst_busy_i,
  output svc_action_t action_o
);

  svc_action_t action_d;
  svc_action_t action_q;
  logic        rst_blocked;

  // A reset pulse issued last cycle has not raised busy yet, so it blocks
  // a second one as well
  assign rst_blocked = rst_busy_i | action_q.domain_reset;

  // ----------------------------------------
  // Group routing, then index decode
  // ----------------------------------------
  always_comb begin
    action_d = '0;
    if (cmd_valid_i) begin
      case (cmd_i.fields.group)
        GRP_OVERRIDE: begin
          case (cmd_i.fields.index)
            4'h0: action_d.awuser_core    = 1'b1;
            4'h1: action_d.awuser_mcu     = 1'b1;
            4'h2: action_d.awuser_release = 1'b1;
            default: ;
          endcase
        end
        GRP_ZEROIZE: begin
          case (cmd_i.fields.index)
            4'h0: action_d.zeroize_set     = 1'b1;
            4'h1: action_d.zeroize_clear   = 1'b1;
            4'h2: action_d.zeroize_release = 1'b1;
            default: ;
          endcase
        end
        GRP_LC: begin
          case (cmd_i.fields.index)
            4'h0: action_d.force_tokens  = 1'b1;
            4'h1: action_d.rma_scrap_ppd = 1'b1;
            4'h2: action_d.escalate      = 1'b1;
            default: ;
          endcase
        end
        GRP_CLK: begin
          case (cmd_i.fields.index)
            4'h0: action_d.clk_500  = 1'b1;
            4'h1: action_d.clk_160  = 1'b1;
            4'h2: action_d.clk_400  = 1'b1;
            4'h3: action_d.clk_1000 = 1'b1;
            default: ;
          endcase
        end
        GRP_FAULT: begin
          case (cmd_i.fields.index)
            4'h0: action_d.fault_bus    = 1'b1;
            4'h1: action_d.fault_digest = 1'b1;
            default: ;
          endcase
        end
        GRP_DOMAIN: begin
          // Single command group, matched on the whole opcode
          if (cmd_i.opcode == CMD_DOMAIN_RESET && !rst_blocked) begin
            action_d.domain_reset = 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      action_q <= '0;
    end else begin
      action_q <= action_d;
    end
  end

  assign action_o = action_q;

  // Datapath modules rely on never seeing two actions together
  action_onehot: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    $onehot0(action_o));

endmodule

`default_nettype wire

// File: verilog/svc_override_regs.sv
`timescale 1ns/1ps
`default_nettype none

module svc_override_regs import svc_pkg::*; (
  input  logic        clk,
  input  logic        cptra_rst_b,
  input  svc_action_t action_i,
  input  logic        clk_byp_ack_i,
  output svc_ctrl_t   ctrl_o
);

  svc_ctrl_t ctrl_q;

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      ctrl_q <= CTRL_RESET;
    end else begin
      // ----------------------------------------
      // Write filter user override
      // ----------------------------------------
      if (action_i.awuser_core) begin
        ctrl_q.awuser_sel <= AWUSER_CORE;
      end
      if (action_i.awuser_mcu) begin
        ctrl_q.awuser_sel <= AWUSER_MCU;
      end
      if (action_i.awuser_release) begin
        ctrl_q.awuser_sel <= AWUSER_NONE;
      end

      // ----------------------------------------
      // Zeroization
      // ----------------------------------------
      if (action_i.zeroize_set) begin
        ctrl_q.zeroize_ppd       <= 1'b1;
        ctrl_q.rom_zero_mask_all <= 1'b1;
        ctrl_q.scrap_mode_n      <= 1'b1;
        ctrl_q.zeroize_forced    <= 1'b1;
      end
      // Clear still counts as forced because it pins the fields to their off values
      if (action_i.zeroize_clear) begin
        ctrl_q.zeroize_ppd       <= 1'b0;
        ctrl_q.rom_zero_mask_all <= 1'b0;
        ctrl_q.scrap_mode_n      <= 1'b0;
        ctrl_q.zeroize_forced    <= 1'b1;
      end
      if (action_i.zeroize_release) begin
        ctrl_q.zeroize_ppd       <= CTRL_RESET.zeroize_ppd;
        ctrl_q.rom_zero_mask_all <= CTRL_RESET.rom_zero_mask_all;
        ctrl_q.scrap_mode_n      <= CTRL_RESET.scrap_mode_n;
        ctrl_q.zeroize_forced    <= 1'b0;
      end

      // Lifecycle flags are sticky until the next reset
      if (action_i.force_tokens) begin
        ctrl_q.tokens_valid <= 1'b1;
      end
      if (action_i.rma_scrap_ppd) begin
        ctrl_q.rma_scrap_ppd <= 1'b1;
      end
      if (action_i.escalate) begin
        ctrl_q.escalate <= 1'b1;
      end

      // ----------------------------------------
      // Clock frequency select
      // ----------------------------------------
      if (action_i.clk_500) begin
        ctrl_q.freq_sel <= F500;
      end
      if (action_i.clk_160) begin
        ctrl_q.freq_sel <= F160;
      end
      if (action_i.clk_400) begin
        ctrl_q.freq_sel <= F400;
      end
      if (action_i.clk_1000) begin
        ctrl_q.freq_sel <= F1000;
      end
    end
  end

  // Without a bypass acknowledge the clock stays on the default source
  always_comb begin
    ctrl_o = ctrl_q;
    if (!clk_byp_ack_i) begin
      ctrl_o.freq_sel = F500;
    end
  end

endmodule

`default_nettype wire

// File: verilog/svc_reset_pulse.sv
`timescale 1ns/1ps
`default_nettype none

module svc_reset_pulse #(
  parameter int RST_HOLD_CYCLES = 10
) (
  input  logic clk,
  input  logic cptra_rst_b,
  input  logic start_i,
  output logic busy_o,
  output logic domain_rst_b_o
);

  localparam int CNT_W = $clog2(RST_HOLD_CYCLES + 1);

  logic             busy_q;
  logic [CNT_W-1:0] cnt_q;

  // The counter holds the cycles left after the current one
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i) begin
      busy_q <= 1'b1;
      cnt_q  <= CNT_W'(RST_HOLD_CYCLES - 1);
    end else if (busy_q) begin
      if (cnt_q == '0) begin
        busy_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  assign busy_o         = busy_q;
  assign domain_rst_b_o = ~busy_q;

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // The decoder must hold back retriggers for the whole window
  no_retrigger: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    start_i |-> !busy_o);

  hold_length: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    $rose(busy_o) |-> busy_o [*RST_HOLD_CYCLES] ##1 !busy_o);

endmodule

`default_nettype wire

// File: verilog/svc_fault_inject.sv
`timescale 1ns/1ps
`default_nettype none

module svc_fault_inject #(
  parameter int DATA_W      = 32,
  parameter int ADDR_W      = 10,
  parameter int DIGEST_ADDR = 696
) (
  input  logic              clk,
  input  logic              cptra_rst_b,
  input  logic              arm_bus_i,
  input  logic              arm_digest_i,
  input  logic              bus_valid_i,
  input  logic [DATA_W-1:0] bus_data_i,
  output logic [DATA_W-1:0] bus_data_o,
  input  logic              mem_rd_valid_i,
  input  logic [ADDR_W-1:0] mem_rd_addr_i,
  input  logic [DATA_W-1:0] mem_rd_data_i,
  output logic [DATA_W-1:0] mem_rd_data_o
);

  logic arm_bus_q;
  logic arm_digest_q;
  logic bus_hit;
  logic digest_hit;

  // A fault lands on the first matching transfer after arming
  assign bus_hit    = bus_valid_i & arm_bus_q;
  assign digest_hit = mem_rd_valid_i & arm_digest_q &
                      (mem_rd_addr_i == ADDR_W'(DIGEST_ADDR));

  // Single bit flip so the bus ECC sees a correctable error
  assign bus_data_o    = bus_hit ? {bus_data_i[DATA_W-1:1], ~bus_data_i[0]} : bus_data_i;
  assign mem_rd_data_o = digest_hit ? '0 : mem_rd_data_i;

  // ----------------------------------------
  // One-shot arm flags
  // ----------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      arm_bus_q    <= 1'b0;
      arm_digest_q <= 1'b0;
    end else begin
      // Consuming wins over a fresh arm in the same cycle
      if (bus_hit) begin
        arm_bus_q <= 1'b0;
      end else if (arm_bus_i) begin
        arm_bus_q <= 1'b1;
      end

      if (digest_hit) begin
        arm_digest_q <= 1'b0;
      end else if (arm_digest_i) begin
        arm_digest_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/svc_top.sv
`timescale 1ns/1ps
`default_nettype none

module svc_top import svc_pkg::*; #(
  parameter int RST_HOLD_CYCLES = 10,
  parameter int DATA_W          = 32,
  parameter int ADDR_W          = 10,
  parameter int DIGEST_ADDR     = 696
) (
  input  logic              clk,
  input  logic              cptra_rst_b,

  // Command strobe from software
  input  logic              cmd_valid_i,
  input  svc_cmd_u          cmd_i,

  input  logic              clk_byp_ack_i,

  // Bus write data path
  input  logic              bus_valid_i,
  input  logic [DATA_W-1:0] bus_data_i,
  output logic [DATA_W-1:0] bus_data_o,

  // Fuse memory read path
  input  logic              mem_rd_valid_i,
  input  logic [ADDR_W-1:0] mem_rd_addr_i,
  input  logic [DATA_W-1:0] mem_rd_data_i,
  output logic [DATA_W-1:0] mem_rd_data_o,

  output svc_ctrl_t         ctrl_o,
  output logic              domain_rst_b_o
);

  svc_action_t action;
  logic        rst_busy;

  svc_cmd_decoder u_cmd_decoder (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .rst_busy_i  (rst_busy),
    .action_o    (action)
  );

  svc_override_regs u_override_regs (
    .clk           (clk),
    .cptra_rst_b   (cptra_rst_b),
    .action_i      (action),
    .clk_byp_ack_i (clk_byp_ack_i),
    .ctrl_o        (ctrl_o)
  );

  svc_reset_pulse #(
    .RST_HOLD_CYCLES (RST_HOLD_CYCLES)
  ) u_reset_pulse (
    .clk            (clk),
    .cptra_rst_b    (cptra_rst_b),
    .start_i        (action.domain_reset),
    .busy_o         (rst_busy),
    .domain_rst_b_o (domain_rst_b_o)
  );

  svc_fault_inject #(
    .DATA_W      (DATA_W),
    .ADDR_W      (ADDR_W),
    .DIGEST_ADDR (DIGEST_ADDR)
  ) u_fault_inject (
    .clk            (clk),
    .cptra_rst_b    (cptra_rst_b),
    .arm_bus_i      (action.fault_bus),
    .arm_digest_i   (action.fault_digest),
    .bus_valid_i    (bus_valid_i),
    .bus_data_i     (bus_data_i),
    .bus_data_o     (bus_data_o),
    .mem_rd_valid_i (mem_rd_valid_i),
    .mem_rd_addr_i  (mem_rd_addr_i),
    .mem_rd_data_i  (mem_rd_data_i),
    .mem_rd_data_o  (mem_rd_data_o)
  );

endmodule

`default_nettype wire

// File: dv/svc_tb_clk.sv
`timescale 1ns/1ps
`default_nettype none

module svc_tb_clk #(
  parameter int PERIOD     = 100,
  parameter int RST_CYCLES = 16
) (
  output logic clk_o,
  output logic cptra_rst_b_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge so the first active edge sees a clean reset
  initial begin
    cptra_rst_b_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    cptra_rst_b_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/svc_checker.sv
`timescale 1ns/1ps
`default_nettype none

module svc_checker import svc_pkg::*; #(
  parameter int RST_HOLD_CYCLES = 10,
  parameter int DATA_W          = 32,
  parameter int ADDR_W          = 10,
  parameter int DIGEST_ADDR     = 696
) (
  input  logic              clk,
  input  logic              cptra_rst_b,
  input  logic [2:0]        test_id_i,
  input  logic              test_done_i,
  // DUT inputs
  input  logic              cmd_valid_i,
  input  logic [7:0]        cmd_i,
  input  logic              clk_byp_ack_i,
  input  logic              bus_valid_i,
  input  logic [DATA_W-1:0] bus_data_i,
  input  logic              mem_rd_valid_i,
  input  logic [ADDR_W-1:0] mem_rd_addr_i,
  input  logic [DATA_W-1:0] mem_rd_data_i,
  // DUT outputs
  input  svc_ctrl_t         ctrl_i,
  input  logic              domain_rst_b_i,
  input  logic [DATA_W-1:0] bus_data_out_i,
  input  logic [DATA_W-1:0] mem_rd_data_out_i,
  output int                pass_cnt_o,
  output int                fail_cnt_o
);

  // Model state, as it stands before the next rising edge
  svc_ctrl_t   ctrl_m;
  int          rst_left;
  logic        arm_bus_m;
  logic        arm_dig_m;
  logic        pend_vld;
  logic [7:0]  pend_cmd;

  int          test_errs;
  string       bad_name;
  logic [63:0] bad_exp;
  logic [63:0] bad_act;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd0: return "reset_values";
      3'd1: return "ctrl_commands";
      3'd2: return "freq_select";
      3'd3: return "domain_reset";
      3'd4: return "fault_inject";
      default: return "unknown";
    endcase
  endfunction

  task automatic reset_model();
    ctrl_m.awuser_sel        = 2'd0;
    ctrl_m.zeroize_ppd       = 1'b0;
    ctrl_m.rom_zero_mask_all = 1'b0;
    ctrl_m.scrap_mode_n      = 1'b1;
    ctrl_m.zeroize_forced    = 1'b0;
    ctrl_m.tokens_valid      = 1'b0;
    ctrl_m.rma_scrap_ppd     = 1'b0;
    ctrl_m.escalate          = 1'b0;
    ctrl_m.freq_sel          = F500;
    rst_left   = 0;
    arm_bus_m  = 1'b0;
    arm_dig_m  = 1'b0;
    pend_vld   = 1'b0;
    pend_cmd   = 8'h00;
    test_errs  = 0;
    pass_cnt_o = 0;
    fail_cnt_o = 0;
  endtask

  // Keeps the first mismatch of the running test for its result line
  task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      if (test_errs == 0) begin
        bad_name = what;
        bad_exp  = exp;
        bad_act  = act;
      end
      test_errs++;
    end
  endtask

  // ----------------------------------------
  // Command effects, one cycle after the strobe
  // ----------------------------------------
  task automatic apply_cmd(input logic [7:0] code, input logic hit_bus, input logic hit_dig);
    case (code)
      CMD_AWUSER_CORE:    ctrl_m.awuser_sel = 2'd1;
      CMD_AWUSER_MCU:     ctrl_m.awuser_sel = 2'd2;
      CMD_RELEASE_AWUSER: ctrl_m.awuser_sel = 2'd0;
      CMD_ZEROIZE_SET: begin
        {ctrl_m.zeroize_ppd, ctrl_m.rom_zero_mask_all} = 2'b11;
        {ctrl_m.scrap_mode_n, ctrl_m.zeroize_forced}   = 2'b11;
      end
      CMD_ZEROIZE_CLEAR: begin
        {ctrl_m.zeroize_ppd, ctrl_m.rom_zero_mask_all} = 2'b00;
        {ctrl_m.scrap_mode_n, ctrl_m.zeroize_forced}   = 2'b01;
      end
      CMD_ZEROIZE_RELEASE: begin
        {ctrl_m.zeroize_ppd, ctrl_m.rom_zero_mask_all} = 2'b00;
        {ctrl_m.scrap_mode_n, ctrl_m.zeroize_forced}   = 2'b10;
      end
      CMD_FORCE_TOKENS:   ctrl_m.tokens_valid  = 1'b1;
      CMD_RMA_SCRAP_PPD:  ctrl_m.rma_scrap_ppd = 1'b1;
      CMD_ESCALATE:       ctrl_m.escalate      = 1'b1;
      CMD_CLK_500:        ctrl_m.freq_sel = F500;
      CMD_CLK_160:        ctrl_m.freq_sel = F160;
      CMD_CLK_400:        ctrl_m.freq_sel = F400;
      CMD_CLK_1000:       ctrl_m.freq_sel = F1000;
      // A transfer that uses up the fault in the same cycle leaves it disarmed
      CMD_FAULT_BUS: begin
        if (!hit_bus) arm_bus_m = 1'b1;
      end
      CMD_FAULT_DIGEST: begin
        if (!hit_dig) arm_dig_m = 1'b1;
      end
      CMD_DOMAIN_RESET:   rst_left = RST_HOLD_CYCLES;
      default: ;
    endcase
  endtask

  task automatic report_test();
    if (test_errs == 0) begin
      $display("%s PASS", test_name(test_id_i));
      pass_cnt_o++;
    end else begin
      $display("ERR %s: %s expected %0h actual %0h (%0d bad cycles)", test_name(test_id_i),
               bad_name, bad_exp, bad_act, test_errs);
      fail_cnt_o++;
    end
    test_errs = 0;
  endtask

  // ----------------------------------------
  // Compare, then advance the model
  // ----------------------------------------
  always @(posedge clk or negedge cptra_rst_b) begin
    svc_ctrl_t         ctrl_exp;
    logic [DATA_W-1:0] bus_exp;
    logic [DATA_W-1:0] mem_exp;
    logic              hit_bus;
    logic              hit_dig;
    logic              blocked;
    if (!cptra_rst_b) begin
      reset_model();
    end else begin
      hit_bus = bus_valid_i && arm_bus_m;
      hit_dig = mem_rd_valid_i && arm_dig_m && (int'(mem_rd_addr_i) == DIGEST_ADDR);

      ctrl_exp = ctrl_m;
      if (!clk_byp_ack_i) ctrl_exp.freq_sel = F500;
      bus_exp = hit_bus ? (bus_data_i ^ DATA_W'(1)) : bus_data_i;
      mem_exp = hit_dig ? '0 : mem_rd_data_i;

      check_val("ctrl_o", 64'(ctrl_exp), 64'(ctrl_i));
      check_val("domain_rst_b_o", 64'(rst_left == 0), 64'(domain_rst_b_i));
      check_val("bus_data_o", 64'(bus_exp), 64'(bus_data_out_i));
      check_val("mem_rd_data_o", 64'(mem_exp), 64'(mem_rd_data_out_i));

      // A reset request is dropped during the window and right after a start
      blocked = (rst_left > 0) || (pend_vld && pend_cmd == CMD_DOMAIN_RESET);
      if (rst_left > 0) rst_left--;
      if (hit_bus) arm_bus_m = 1'b0;
      if (hit_dig) arm_dig_m = 1'b0;
      if (pend_vld) apply_cmd(pend_cmd, hit_bus, hit_dig);
      pend_vld = cmd_valid_i && !(cmd_i == CMD_DOMAIN_RESET && blocked);
      pend_cmd = cmd_i;

      if (test_done_i) report_test();
    end
  end

endmodule

`default_nettype wire

// File: dv/svc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module svc_tb import svc_pkg::*;;

  localparam logic [31:0] SEED      = 32'hce6a40d1;
  localparam int CLK_PERIOD         = 100;
  localparam int RST_CYCLES         = 16;
  localparam int RST_HOLD_CYCLES    = 10;
  localparam int DATA_W             = 32;
  localparam int ADDR_W             = 10;
  localparam int DIGEST_ADDR        = 696;

  localparam int NUM_TESTS  = 5;
  localparam int RESET_LEN  = 8;
  localparam int CTRL_LEN   = 400;
  localparam int FREQ_LEN   = 300;
  localparam int DOMAIN_LEN = 300;
  localparam int FAULT_LEN  = 400;
  localparam int DRAIN_LEN  = RST_HOLD_CYCLES + 4;
  localparam int TOTAL_CYCLES = RST_CYCLES + RESET_LEN + CTRL_LEN + FREQ_LEN + DOMAIN_LEN +
                                FAULT_LEN + NUM_TESTS * (DRAIN_LEN + 2) + 4;

  logic              clk;
  logic              cptra_rst_b;
  logic              cmd_valid;
  logic [7:0]        cmd;
  logic              clk_byp_ack;
  logic              bus_valid;
  logic [DATA_W-1:0] bus_data;
  logic [DATA_W-1:0] bus_data_out;
  logic              mem_rd_valid;
  logic [ADDR_W-1:0] mem_rd_addr;
  logic [DATA_W-1:0] mem_rd_data;
  logic [DATA_W-1:0] mem_rd_data_out;
  svc_ctrl_t         ctrl;
  logic              domain_rst_b;
  logic [2:0]        test_id;
  logic              test_done;
  int                pass_cnt;
  int                fail_cnt;
  logic [31:0]       rng;

  svc_tb_clk #(
    .PERIOD     (CLK_PERIOD),
    .RST_CYCLES (RST_CYCLES)
  ) clk_gen (
    .clk_o         (clk),
    .cptra_rst_b_o (cptra_rst_b)
  );

  svc_top #(
    .RST_HOLD_CYCLES (RST_HOLD_CYCLES),
    .DATA_W          (DATA_W),
    .ADDR_W          (ADDR_W),
    .DIGEST_ADDR     (DIGEST_ADDR)
  ) svc_top_inst (
    .clk            (clk),
    .cptra_rst_b    (cptra_rst_b),
    .cmd_valid_i    (cmd_valid),
    .cmd_i          (cmd),
    .clk_byp_ack_i  (clk_byp_ack),
    .bus_valid_i    (bus_valid),
    .bus_data_i     (bus_data),
    .bus_data_o     (bus_data_out),
    .mem_rd_valid_i (mem_rd_valid),
    .mem_rd_addr_i  (mem_rd_addr),
    .mem_rd_data_i  (mem_rd_data),
    .mem_rd_data_o  (mem_rd_data_out),
    .ctrl_o         (ctrl),
    .domain_rst_b_o (domain_rst_b)
  );

  svc_checker #(
    .RST_HOLD_CYCLES (RST_HOLD_CYCLES),
    .DATA_W          (DATA_W),
    .ADDR_W          (ADDR_W),
    .DIGEST_ADDR     (DIGEST_ADDR)
  ) checker_inst (
    .clk               (clk),
    .cptra_rst_b       (cptra_rst_b),
    .test_id_i         (test_id),
    .test_done_i       (test_done),
    .cmd_valid_i       (cmd_valid),
    .cmd_i             (cmd),
    .clk_byp_ack_i     (clk_byp_ack),
    .bus_valid_i       (bus_valid),
    .bus_data_i        (bus_data),
    .mem_rd_valid_i    (mem_rd_valid),
    .mem_rd_addr_i     (mem_rd_addr),
    .mem_rd_data_i     (mem_rd_data),
    .ctrl_i            (ctrl),
    .domain_rst_b_i    (domain_rst_b),
    .bus_data_out_i    (bus_data_out),
    .mem_rd_data_out_i (mem_rd_data_out),
    .pass_cnt_o        (pass_cnt),
    .fail_cnt_o        (fail_cnt)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ----------------------------------------
  // Command choice per test
  // ----------------------------------------
  // Codes outside the tables fall back to a random byte, mostly unknown opcodes
  function automatic logic [7:0] pick_cmd(input int test, input logic [31:0] r);
    logic [7:0] code;
    code = r[15:8];
    case (test)
      1: begin
        case (r[3:0])
          4'd0: code = CMD_AWUSER_CORE;
          4'd1: code = CMD_AWUSER_MCU;
          4'd2: code = CMD_RELEASE_AWUSER;
          4'd3: code = CMD_ZEROIZE_SET;
          4'd4: code = CMD_ZEROIZE_CLEAR;
          4'd5: code = CMD_ZEROIZE_RELEASE;
          4'd6: code = CMD_FORCE_TOKENS;
          4'd7: code = CMD_RMA_SCRAP_PPD;
          4'd8: code = CMD_ESCALATE;
          4'd9: code = 8'h13;
          4'd10: code = 8'h2f;
          4'd11: code = 8'h35;
          default: ;
        endcase
      end
      2: begin
        case (r[1:0])
          2'd0: code = CMD_CLK_500;
          2'd1: code = CMD_CLK_160;
          2'd2: code = CMD_CLK_400;
          default: code = CMD_CLK_1000;
        endcase
        if (r[3:2] == 2'd3) code = 8'h44;
      end
      3: begin
        code = CMD_DOMAIN_RESET;
        if (r[3:0] == 4'd0) code = CMD_CLK_160;
        if (r[3:0] == 4'd1) code = 8'h61;
      end
      4: begin
        code = r[0] ? CMD_FAULT_BUS : CMD_FAULT_DIGEST;
        if (r[3:1] == 3'd0) code = 8'h52;
      end
      default: ;
    endcase
    return code;
  endfunction

  // One cycle of random stimulus, applied on the falling edge
  task automatic drive_cycle(input int test, input logic allow_cmd);
    logic [31:0] r_ctl;
    logic [31:0] r_bus;
    logic [31:0] r_mem;
    @(negedge clk);
    rng = xorshift32(rng);
    r_ctl = rng;
    rng = xorshift32(rng);
    r_bus = rng;
    rng = xorshift32(rng);
    r_mem = rng;
    case (test)
      0: cmd_valid = 1'b0;
      3: cmd_valid = (r_ctl[6:4] != 3'd0);
      4: cmd_valid = (r_ctl[5:4] == 2'd0);
      default: cmd_valid = r_ctl[4];
    endcase
    if (!allow_cmd) cmd_valid = 1'b0;
    cmd          = pick_cmd(test, r_ctl);
    clk_byp_ack  = (test != 0) && r_ctl[31];
    bus_valid    = r_ctl[30];
    bus_data     = r_bus;
    mem_rd_valid = r_ctl[29];
    // About a quarter of the reads hit the digest word
    mem_rd_addr  = (r_ctl[28:27] == 2'd0) ? ADDR_W'(DIGEST_ADDR) : r_ctl[ADDR_W+15:16];
    mem_rd_data  = r_mem;
  endtask

  task automatic run_test(input int test, input int len);
    test_id = 3'(test);
    for (int i = 0; i < len; i++) begin
      drive_cycle(test, 1'b1);
    end
    // Let a late reset window run out before the result is taken
    for (int i = 0; i < DRAIN_LEN; i++) begin
      drive_cycle(test, 1'b0);
    end
    @(negedge clk);
    test_done = 1'b1;
    @(negedge clk);
    test_done = 1'b0;
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    cmd_valid    = 1'b0;
    cmd          = 8'h00;
    clk_byp_ack  = 1'b0;
    bus_valid    = 1'b0;
    bus_data     = '0;
    mem_rd_valid = 1'b0;
    mem_rd_addr  = '0;
    mem_rd_data  = '0;
    test_id      = 3'd0;
    test_done    = 1'b0;
    rng          = SEED;
    @(posedge cptra_rst_b);
    run_test(0, RESET_LEN);
    run_test(1, CTRL_LEN);
    run_test(2, FREQ_LEN);
    run_test(3, DOMAIN_LEN);
    run_test(4, FAULT_LEN);
    @(negedge clk);
    $display("%0d tests run, %0d passed, %0d failed", NUM_TESTS, pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt == NUM_TESTS) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #((TOTAL_CYCLES + 200) * CLK_PERIOD);
    $display("Watchdog expired before the test sequence finished");
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
verilog/svc_pkg.sv
verilog/svc_cmd_decoder.sv
verilog/svc_override_regs.sv
verilog/svc_reset_pulse.sv
verilog/svc_fault_inject.sv
verilog/svc_top.sv
dv/svc_tb_clk.sv
dv/svc_checker.sv
dv/svc_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then judge the log
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module svc_tb -f list.f -o svc_sim

# The log is searched below, so a failing run still gets a verdict
./obj_dir/svc_sim | tee sim.log

if grep -qx "all tests passed" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
